// ==== sim.f ====
+incdir+hdl
hdl/batt_mon_pkg.sv
hdl/volt_averager.sv
hdl/record_fifo.sv
hdl/telemetry_tx.sv
hdl/batt_mon_top.sv
dv/batt_mon_assertions.sv
dv/batt_mon_tb.sv

// ==== Makefile ====
# Verilator build and run of the battery monitor testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the build directory and the log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --top-module batt_mon_tb -f sim.f -o batt_mon_sim
	./obj_dir/batt_mon_sim > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/batt_mon_tb.sv ====
/*
 * Testbench for the battery monitor. Each table row is one block of 256
 * noisy samples; the flag and every packet byte are checked against the
 * averaging and threshold rules. A UART model drives busy after each byte.
 */

`timescale 1ns/1ps
`default_nettype none

`include "batt_mon_defs.svh"

module batt_mon_tb;

    localparam int reset_cycles    = 8;
    localparam int block_len       = 1 << `BATT_MON_AVG_LOG2;
    localparam int busy_hold       = 6;                         // Busy cycles per byte
    localparam int keep_limit      = `BATT_MON_FIFO_DEPTH + 2;  // Tx, FIFO and pending write
    localparam int num_rows        = 18;
    localparam int watchdog_cycles = reset_cycles + num_rows * block_len * 2 + 4000;

    typedef struct packed {
        batt_mon_pkg::batt_kind_t kind;
        batt_mon_pkg::volt_t      level;       // Intended block mean
        logic                     charging;
        logic [3:0]               hold_busy;   // Averages with busy forced high
        logic                     exp_low;
    } row_t;

    logic                      clk;
    logic                      reset;
    logic                      adc_valid;
    batt_mon_pkg::volt_t       adc_value;
    batt_mon_pkg::batt_kind_t  bat_kind;
    logic                      charging;
    logic                      uart_tx_busy;
    wire                       low_battery;
    wire [7:0]                 uart_tx_data;
    wire                       uart_tx_val;

    row_t                      stim_table [num_rows];
    batt_mon_pkg::volt_rec_t   exp_q [$];
    logic [15:0]               lfsr_state;
    logic                      force_busy;
    logic                      exp_low;
    int                        force_left;
    int                        kept;
    int                        byte_idx;
    int                        busy_left;
    logic                      val_seen;
    batt_mon_pkg::volt_rec_t   cur_rec;
    logic [7:0]                hi_byte;

    batt_mon_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .adc_valid    (adc_valid),
        .adc_value    (adc_value),
        .bat_kind     (bat_kind),
        .charging     (charging),
        .low_battery  (low_battery),
        .uart_tx_data (uart_tx_data),
        .uart_tx_val  (uart_tx_val),
        .uart_tx_busy (uart_tx_busy)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic compare_volt(input string name, input batt_mon_pkg::volt_t exp,
                                input batt_mon_pkg::volt_t act);
        if (act !== exp) begin
            stop_run($sformatf("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act));
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("Fail at %0t: %s expected %b, got %b", $time, name, exp, act));
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Fail at %0t: %s expected 0x%02h, got 0x%02h",
                               $time, name, exp, act));
        end
    endtask

    // Galois form, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            lfsr_step = (state >> 1) ^ 16'hB400;
        end else begin
            lfsr_step = state >> 1;
        end
    endfunction

    task automatic take_noise(output logic [2:0] noise);
        noise = 3'd0;
        for (int b = 0; b < 3; b++) begin
            noise      = {noise[1:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [7:0] header_for(input batt_mon_pkg::batt_kind_t kind);
        if (kind == batt_mon_pkg::batt_li) begin
            header_for = `BATT_MON_CH_LI;
        end else begin
            header_for = `BATT_MON_CH_AA;
        end
    endfunction

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_block(input row_t row);
        logic [2:0]               noise [block_len];
        int                       noise_sum;
        int                       base;
        int                       sum;
        batt_mon_pkg::volt_rec_t  rec;
        noise_sum = 0;
        sum       = 0;
        for (int i = 0; i < block_len; i++) begin
            take_noise(noise[i]);
            noise_sum += int'(noise[i]);
        end
        // Whole part of the noise mean comes off the base
        base = int'(row.level) - (noise_sum >> `BATT_MON_AVG_LOG2);
        @(negedge clk);
        bat_kind = row.kind;
        charging = row.charging;
        for (int i = 0; i < block_len; i++) begin
            @(negedge clk);
            compare_flag("low_battery", exp_low, low_battery);
            adc_valid = 1'b1;
            adc_value = batt_mon_pkg::volt_t'(base + int'(noise[i]));
            sum      += base + int'(noise[i]);
            @(negedge clk);
            adc_valid = 1'b0;
        end
        rec.kind = row.kind;
        rec.volt = batt_mon_pkg::volt_t'(sum >> `BATT_MON_AVG_LOG2);   // Truncated mean
        exp_low  = row.exp_low;
        compare_flag("low_battery", exp_low, low_battery);
        if (force_left > 0) begin
            if (kept < keep_limit) begin
                exp_q.push_back(rec);
            end
            kept++;
            force_left--;
            if (force_left == 0) begin
                @(posedge clk);
                force_busy = 1'b0;                 // Held records drain now
            end
        end else begin
            exp_q.push_back(rec);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // UART model, busy for a few cycles after each byte
    initial begin
        uart_tx_busy = 1'b0;
        busy_left    = 0;
        forever begin
            @(posedge clk);
            val_seen = uart_tx_val;
            @(negedge clk);
            if (val_seen) begin
                busy_left = busy_hold;
            end else if (busy_left > 0) begin
                busy_left--;
            end
            uart_tx_busy = force_busy || (busy_left > 0);
        end
    end

    // Packet checker
    always @(posedge clk) begin
        if (!reset && uart_tx_val) begin
            if (byte_idx == 0) begin
                if (exp_q.size() == 0) begin
                    stop_run("A UART byte was sent while no packet was expected");
                end else begin
                    cur_rec = exp_q[0];
                    compare_byte("uart_tx_data header", header_for(cur_rec.kind), uart_tx_data);
                    byte_idx = 1;
                end
            end else if (byte_idx == 1) begin
                compare_byte("uart_tx_data high", {2'b00, cur_rec.volt[13:8]}, uart_tx_data);
                hi_byte  = uart_tx_data;
                byte_idx = 2;
            end else begin
                compare_volt("packet voltage", cur_rec.volt, {hi_byte[5:0], uart_tx_data});
                void'(exp_q.pop_front());
                byte_idx = 0;
            end
        end
    end

    always @(negedge clk) begin
        if (dut_i.assertions_i.fail_count != 0) begin
            stop_run("A Wishbone or UART protocol assertion failed");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_run("Timeout: the table did not finish in the allowed time");
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset        = 1'b1;
        adc_valid    = 1'b0;
        adc_value    = '0;
        bat_kind     = batt_mon_pkg::batt_aa;
        charging     = 1'b0;
        force_busy   = 1'b0;
        exp_low      = 1'b0;
        force_left   = 0;
        kept         = 0;
        byte_idx     = 0;
        lfsr_state   = 16'd3;
        // kind, mean, charging, busy hold, expected flag
        stim_table[0]  = '{batt_mon_pkg::batt_aa, 14'd1500,  1'b0, 4'd0, 1'b0};
        stim_table[1]  = '{batt_mon_pkg::batt_aa, 14'd1251,  1'b0, 4'd0, 1'b1};
        stim_table[2]  = '{batt_mon_pkg::batt_aa, 14'd1252,  1'b0, 4'd0, 1'b0};
        stim_table[3]  = '{batt_mon_pkg::batt_li, 14'd1181,  1'b0, 4'd0, 1'b1};
        stim_table[4]  = '{batt_mon_pkg::batt_li, 14'd1182,  1'b0, 4'd0, 1'b0};
        stim_table[5]  = '{batt_mon_pkg::batt_aa, 14'd699,   1'b0, 4'd0, 1'b0};
        stim_table[6]  = '{batt_mon_pkg::batt_aa, 14'd700,   1'b0, 4'd0, 1'b1};
        stim_table[7]  = '{batt_mon_pkg::batt_aa, 14'd1000,  1'b1, 4'd0, 1'b0};
        stim_table[8]  = '{batt_mon_pkg::batt_li, 14'd1100,  1'b1, 4'd0, 1'b0};
        stim_table[9]  = '{batt_mon_pkg::batt_li, 14'd1000,  1'b0, 4'd8, 1'b1};
        stim_table[10] = '{batt_mon_pkg::batt_aa, 14'd1300,  1'b0, 4'd0, 1'b0};
        stim_table[11] = '{batt_mon_pkg::batt_li, 14'd1200,  1'b0, 4'd0, 1'b0};
        stim_table[12] = '{batt_mon_pkg::batt_aa, 14'd1251,  1'b0, 4'd0, 1'b1};
        stim_table[13] = '{batt_mon_pkg::batt_li, 14'd900,   1'b0, 4'd0, 1'b1};
        stim_table[14] = '{batt_mon_pkg::batt_aa, 14'd12000, 1'b0, 4'd0, 1'b0};
        stim_table[15] = '{batt_mon_pkg::batt_aa, 14'd2000,  1'b0, 4'd0, 1'b0};
        stim_table[16] = '{batt_mon_pkg::batt_aa, 14'd1240,  1'b0, 4'd0, 1'b1};
        stim_table[17] = '{batt_mon_pkg::batt_li, 14'd5000,  1'b0, 4'd0, 1'b0};
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            if (stim_table[r].hold_busy != 4'd0) begin
                wait_drained();                    // Start the stall from an empty pipe
                @(posedge clk);
                force_busy = 1'b1;
                force_left = int'(stim_table[r].hold_busy);
                kept       = 0;
            end
            run_block(stim_table[r]);
        end
        wait_drained();
        repeat (40) @(negedge clk);                // Quiet period, no stray bytes
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/batt_mon_assertions.sv ====
/*
 * Protocol checks for the battery monitor, bound into the top level.
 * Covers both Wishbone links and the UART byte strobe.
 */

`timescale 1ns/1ps
`default_nettype none

module batt_mon_assertions (
    input wire clk,
    input wire reset,
    input wire wr_stb,
    input wire wr_ack,
    input wire rd_cyc,
    input wire rd_stb,
    input wire rd_ack,
    input wire uart_tx_val,
    input wire uart_tx_busy
);

    int fail_count = 0;     // Read by the testbench

    wr_stb_held: assert property (@(posedge clk) disable iff (reset)
        wr_stb && !wr_ack |=> wr_stb)
        else begin
            $error("Write strobe dropped before ack");
            fail_count++;
        end

    wr_ack_stb: assert property (@(posedge clk) disable iff (reset)
        wr_ack |-> wr_stb)
        else begin
            $error("Write ack without strobe");
            fail_count++;
        end

    rd_stb_held: assert property (@(posedge clk) disable iff (reset)
        rd_stb && rd_cyc && !rd_ack |=> rd_stb)
        else begin
            $error("Read strobe dropped before ack");
            fail_count++;
        end

    rd_ack_stb: assert property (@(posedge clk) disable iff (reset)
        rd_ack |-> rd_stb)
        else begin
            $error("Read ack without strobe");
            fail_count++;
        end

    val_spacing: assert property (@(posedge clk) disable iff (reset)
        uart_tx_val |=> !uart_tx_val)
        else begin
            $error("UART strobe in two consecutive cycles");
            fail_count++;
        end

    val_not_busy: assert property (@(posedge clk) disable iff (reset)
        uart_tx_val |-> !uart_tx_busy)
        else begin
            $error("UART strobe while busy");
            fail_count++;
        end

endmodule

bind batt_mon_top batt_mon_assertions assertions_i (
    .clk          (clk),
    .reset        (reset),
    .wr_stb       (wr_stb),
    .wr_ack       (wr_ack),
    .rd_cyc       (rd_cyc),
    .rd_stb       (rd_stb),
    .rd_ack       (rd_ack),
    .uart_tx_val  (uart_tx_val),
    .uart_tx_busy (uart_tx_busy)
);

`default_nettype wire

// ==== hdl/batt_mon_top.sv ====
/*
 * Battery monitor top level. The averager writes one record per 256
 * samples into the record FIFO, and the telemetry transmitter drains it
 * towards the UART byte interface. Both internal links are Wishbone
 * classic.
 */

`timescale 1ns/1ps
`default_nettype none

`include "batt_mon_defs.svh"

module batt_mon_top (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           adc_valid,
    input  wire batt_mon_pkg::volt_t      adc_value,
    input  wire batt_mon_pkg::batt_kind_t bat_kind,
    input  wire                           charging,       // PMIC charging status
    output wire                           low_battery,
    output wire [7:0]                     uart_tx_data,
    output wire                           uart_tx_val,
    input  wire                           uart_tx_busy
);

    // Averager to FIFO
    wire                          wr_cyc;
    wire                          wr_stb;
    wire                          wr_we;
    batt_mon_pkg::volt_rec_t      wr_dat;
    wire                          wr_ack;

    // FIFO to transmitter
    wire                          rd_cyc;
    wire                          rd_stb;
    batt_mon_pkg::volt_rec_t      rd_dat;
    wire                          rd_ack;

    volt_averager averager_i (
        .clk         (clk),
        .reset       (reset),
        .adc_valid   (adc_valid),
        .adc_value   (adc_value),
        .bat_kind    (bat_kind),
        .charging    (charging),
        .low_battery (low_battery),
        .wr_cyc      (wr_cyc),
        .wr_stb      (wr_stb),
        .wr_we       (wr_we),
        .wr_dat      (wr_dat),
        .wr_ack      (wr_ack)
    );

    record_fifo #(
        .payload_t (batt_mon_pkg::volt_rec_t),
        .depth     (`BATT_MON_FIFO_DEPTH)
    ) fifo_i (
        .clk    (clk),
        .reset  (reset),
        .wr_cyc (wr_cyc),
        .wr_stb (wr_stb),
        .wr_we  (wr_we),
        .wr_dat (wr_dat),
        .wr_ack (wr_ack),
        .rd_cyc (rd_cyc),
        .rd_stb (rd_stb),
        .rd_dat (rd_dat),
        .rd_ack (rd_ack)
    );

    telemetry_tx tx_i (
        .clk          (clk),
        .reset        (reset),
        .rd_cyc       (rd_cyc),
        .rd_stb       (rd_stb),
        .rd_dat       (rd_dat),
        .rd_ack       (rd_ack),
        .uart_tx_data (uart_tx_data),
        .uart_tx_val  (uart_tx_val),
        .uart_tx_busy (uart_tx_busy)
    );

endmodule

`default_nettype wire

// ==== hdl/telemetry_tx.sv ====
/*
 * Reads telemetry records over a Wishbone classic read link and sends each
 * one to the UART as a three-byte packet: channel header, then the high
 * and low voltage bytes. A byte goes out only when the UART is not busy
 * and no byte went out in the cycle before, covering the lag of busy.
 */

`timescale 1ns/1ps
`default_nettype none

`include "batt_mon_defs.svh"

module telemetry_tx (
    input  wire                          clk,
    input  wire                          reset,
    output logic                         rd_cyc,
    output logic                         rd_stb,
    input  wire batt_mon_pkg::volt_rec_t rd_dat,
    input  wire                          rd_ack,
    output logic [7:0]                   uart_tx_data,
    output logic                         uart_tx_val,
    input  wire                          uart_tx_busy
);

    typedef enum logic [1:0] {
        st_read,                       // Fetch next record
        st_hdr,
        st_hi,
        st_lo
    } state_t;

    state_t                   state;
    batt_mon_pkg::volt_rec_t  rec;
    logic                     val_q;   // Byte issued last cycle
    logic                     send;

    assign send        = (state != st_read) && !uart_tx_busy && !val_q;
    assign uart_tx_val = send;

    always_comb begin
        case (state)
            st_hdr:  uart_tx_data = (rec.kind == batt_mon_pkg::batt_li) ? `BATT_MON_CH_LI
                                                                        : `BATT_MON_CH_AA;
            st_hi:   uart_tx_data = {2'b00, rec.volt[13:8]};
            st_lo:   uart_tx_data = rec.volt[7:0];
            default: uart_tx_data = 8'd0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= st_read;
            rd_cyc <= 1'b0;
            rd_stb <= 1'b0;
            val_q  <= 1'b0;
        end else begin
            val_q <= send;
            case (state)
                st_read: begin
                    if (rd_ack) begin
                        rd_cyc <= 1'b0;
                        rd_stb <= 1'b0;
                        state  <= st_hdr;
                    end else begin
                        rd_cyc <= 1'b1;    // Waits here while the FIFO is empty
                        rd_stb <= 1'b1;
                    end
                end
                st_hdr: if (send) state <= st_hi;
                st_hi:  if (send) state <= st_lo;
                st_lo:  if (send) state <= st_read;
                default: state <= st_read;
            endcase
        end
    end

    // Record held for the whole packet
    always_ff @(posedge clk) begin
        if (state == st_read && rd_ack) begin
            rec <= rd_dat;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/record_fifo.sv ====
/*
 * Record buffer between two Wishbone classic links. Both sides are
 * slaves: the write side stores one entry per ack, the read side returns
 * the oldest entry with its ack. Acks are registered and withheld while
 * full or empty. Depth is a power of two of at least two.
 */

`timescale 1ns/1ps
`default_nettype none

`include "batt_mon_defs.svh"

module record_fifo #(
    parameter type payload_t = batt_mon_pkg::volt_rec_t,
    parameter int  depth     = `BATT_MON_FIFO_DEPTH
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            wr_cyc,
    input  wire            wr_stb,
    input  wire            wr_we,
    input  wire payload_t  wr_dat,
    output logic           wr_ack,
    input  wire            rd_cyc,
    input  wire            rd_stb,
    output payload_t       rd_dat,
    output logic           rd_ack
);

    localparam int ptr_w = $clog2(depth);

    payload_t          mem [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [ptr_w:0]    count;          // Occupancy, 0 to depth
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;

    assign full  = (count == (ptr_w + 1)'(depth));
    assign empty = (count == '0);

    // No second ack while the master still holds stb
    assign push = wr_cyc && wr_stb && wr_we && !wr_ack && !full;
    assign pop  = rd_cyc && rd_stb && !rd_ack && !empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= push;
            rd_ack <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_dat;
        end
        if (pop) begin
            rd_dat <= mem[rd_ptr];     // Valid together with rd_ack
        end
    end

endmodule

`default_nettype wire

// ==== hdl/volt_averager.sv ====
/*
 * Averages raw ADC samples in blocks of 256 and derives the low-battery
 * flag from each average. Every average is offered as a telemetry record
 * on a Wishbone classic write link; averages that complete while a write
 * is still pending are dropped. Sampling never stalls.
 */

`timescale 1ns/1ps
`default_nettype none

`include "batt_mon_defs.svh"

module volt_averager (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              adc_valid,
    input  wire batt_mon_pkg::volt_t         adc_value,
    input  wire batt_mon_pkg::batt_kind_t    bat_kind,
    input  wire                              charging,
    output logic                             low_battery,
    output logic                             wr_cyc,
    output logic                             wr_stb,
    output logic                             wr_we,
    output batt_mon_pkg::volt_rec_t          wr_dat,
    input  wire                              wr_ack
);

    logic [`BATT_MON_SUM_W-1:0]    sum;
    logic [`BATT_MON_AVG_LOG2:0]   cnt;        // Top bit marks a full block
    logic [`BATT_MON_SUM_W-1:0]    sum_next;
    logic [`BATT_MON_AVG_LOG2:0]   cnt_next;
    batt_mon_pkg::volt_t           avg_next;
    batt_mon_pkg::volt_t           red_thresh;
    logic                          block_done;
    logic                          low_next;
    logic                          wr_pending;

    assign sum_next = sum + `BATT_MON_SUM_W'(adc_value);
    assign cnt_next = cnt + 1'b1;

    // 256th sample accepted this cycle
    assign block_done = adc_valid && cnt_next[`BATT_MON_AVG_LOG2];

    // Truncated mean, sum >> 8
    assign avg_next = sum_next[`BATT_MON_SUM_W-1 -: `BATT_MON_VOLT_W];

    assign red_thresh = (bat_kind == batt_mon_pkg::batt_li) ? `BATT_MON_RED_LI
                                                            : `BATT_MON_RED_AA;

    // Low only with a real battery that is not on the charger
    assign low_next = (avg_next >= `BATT_MON_VALID_MIN) && !charging &&
                      (avg_next < red_thresh);

    // Previous record not yet taken, includes the ack cycle
    assign wr_pending = wr_stb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum         <= '0;
            cnt         <= '0;
            low_battery <= 1'b0;
        end else if (adc_valid) begin
            if (block_done) begin
                sum         <= '0;
                cnt         <= '0;
                low_battery <= low_next;   // Flag updates even if record is dropped
            end else begin
                sum <= sum_next;
                cnt <= cnt_next;
            end
        end
    end

    // Wishbone classic write master
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_cyc <= 1'b0;
            wr_stb <= 1'b0;
            wr_we  <= 1'b0;
        end else if (wr_stb && wr_ack) begin
            wr_cyc <= 1'b0;                // End of cycle after ack
            wr_stb <= 1'b0;
            wr_we  <= 1'b0;
        end else if (block_done && !wr_pending) begin
            wr_cyc <= 1'b1;
            wr_stb <= 1'b1;
            wr_we  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (block_done && !wr_pending) begin
            wr_dat.kind <= bat_kind;
            wr_dat.volt <= avg_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/batt_mon_pkg.sv ====
/*
 * Types shared by the battery monitor blocks. The telemetry record is
 * the payload carried on both Wishbone links between producer, buffer
 * and consumer. Refer to the types by scoped name.
 */

`default_nettype none

`include "batt_mon_defs.svh"

package batt_mon_pkg;

    // Unsigned ADC voltage code
    typedef logic [`BATT_MON_VOLT_W-1:0] volt_t;

    // Battery chemistry from the board strap
    typedef enum logic {
        batt_aa = 1'b0,
        batt_li = 1'b1
    } batt_kind_t;

    // One averaged measurement, 15 bits
    typedef struct packed {
        batt_kind_t kind;
        volt_t      volt;
    } volt_rec_t;

endpackage

`default_nettype wire

// ==== hdl/batt_mon_defs.svh ====
/*
 * Shared constants for the battery monitor: widths, averaging length,
 * low-battery thresholds, FIFO depth and UART channel header codes.
 * Include wherever one of these values is needed.
 */

`ifndef BATT_MON_DEFS_SVH
`define BATT_MON_DEFS_SVH

// Voltage codes and averaging
`define BATT_MON_VOLT_W     14          // Raw or averaged ADC code
`define BATT_MON_AVG_LOG2   8           // 256 samples per average
`define BATT_MON_SUM_W      22          // VOLT_W + AVG_LOG2

// Raw code g(V) = (V + 0.1) * 2.2 / 12.2 * 2048
`define BATT_MON_VALID_MIN  14'd700     // ~1.8 V, below is no battery
`define BATT_MON_RED_AA     14'd1252    // ~3.29 V for AA cells
`define BATT_MON_RED_LI     14'd1182    // ~3.1 V for lithium

// Record buffer
`define BATT_MON_FIFO_DEPTH 4

// Packet header bytes
`define BATT_MON_CH_AA      8'd0
`define BATT_MON_CH_LI      8'd1

`endif
